// ==== logic/xv_defs.svh ====
// xv defines: bus register numbers, xr decode codes, palette size and frame timing
`ifndef XV_DEFS_SVH
`define XV_DEFS_SVH

// cpu bus register numbers (bus_reg_num_i)
`define XV_REG_XR_ADDR      4'd0    // xr address, auto-increments after each xr write
`define XV_REG_XR_DATA      4'd1    // xr data, odd byte write starts the transfer
`define XV_REG_SYS_CTRL     4'd2    // bit 0 intr mask, read gives busy/mask/status
`define XV_REG_INT_CLEAR    4'd3    // bit 0 clears pending vblank status

// xr memory region code, bits [13:12] of a memory view address
`define XV_XR_REGION_COLOR  2'd0    // color palette

// xr video register numbers
`define XV_VREG_COLOR_BASE  5'd0    // ramp base added to pixel x

// palette size in entries
`define XV_PAL_DEPTH        256

// horizontal timing, in pixel clocks
// visible, front porch, sync, back porch
`define XV_H_VISIBLE        16
`define XV_H_SYNC_START     18
`define XV_H_SYNC_END       20      // first clock after sync
`define XV_H_TOTAL          24

// vertical timing, in lines
`define XV_V_VISIBLE        6
`define XV_V_SYNC_START     7
`define XV_V_SYNC_END       9       // first line after sync
`define XV_V_TOTAL          10

// a full frame is 240 clocks at these numbers
// vblank starts on line XV_V_VISIBLE, h = 0

`endif

// ==== logic/xv_pkg.sv ====
// xv package: two views of the xr address and the palette word types
`default_nettype none

package xv_pkg;

    // register view, top bit clear
    typedef struct packed {
        logic        is_mem;    // 0 for registers
        logic [9:0]  unused;
        logic [4:0]  reg_num;   // video register number
    } xr_reg_view_t;

    // memory view, top bit set
    typedef struct packed {
        logic        is_mem;    // 1 for memories
        logic        unused;
        logic [1:0]  region;    // which xr memory
        logic [11:0] offset;    // word offset in region
    } xr_mem_view_t;

    // one 16-bit xr address, decoded by its top bit
    typedef union packed {
        xr_reg_view_t regs;
        xr_mem_view_t mem;
    } xr_addr_t;

    // palette word, [11:8] red, [7:4] green, [3:0] blue, top nibble spare
    typedef logic [15:0] pal_entry_t;

    // palette index
    typedef logic [7:0] color_index_t;

endpackage

`default_nettype wire

// ==== logic/xv_bus_regs.sv ====
// xv bus registers: cpu byte bus decode, xr write requester and vblank interrupt
`default_nettype none
`timescale 1ns/1ps

`include "xv_defs.svh"

module xv_bus_regs (
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire logic           bus_cs_n_i,         // one access per low cycle
    input  wire logic           bus_rd_nwr_i,       // 1 = read, 0 = write
    input  wire logic [3:0]     bus_reg_num_i,      // register number
    input  wire logic           bus_bytesel_i,      // 0 = even (high), 1 = odd (low)
    input  wire logic [7:0]     bus_data_i,
    output logic      [7:0]     bus_data_o,         // read data, cycle after access
    output logic                bus_intr_o,         // one-cycle interrupt pulse
    output logic                xr_req_o,           // four-phase request
    input  wire logic           xr_ack_i,           // four-phase ack from palette side
    output xv_pkg::xr_addr_t    xr_addr_o,          // stable while req high
    output logic      [15:0]    xr_data_o,          // stable while req high
    input  wire logic           vblank_start_i      // one pulse per frame
);

    logic [7:0]  even_byte;     // held high byte
    logic [15:0] wr_word;       // held byte + odd byte
    logic        even_wr;
    logic        wr_stb;        // word complete
    logic        rd_stb;
    logic        busy;          // req or ack still up
    logic        xr_start;
    logic        intr_mask;
    logic        intr_status;   // pending vblank
    logic        intr_clear;

    assign even_wr  = !bus_cs_n_i && !bus_rd_nwr_i && !bus_bytesel_i;
    assign wr_stb   = !bus_cs_n_i && !bus_rd_nwr_i && bus_bytesel_i;
    assign rd_stb   = !bus_cs_n_i && bus_rd_nwr_i;
    assign wr_word  = {even_byte, bus_data_i};
    assign busy     = xr_req_o || xr_ack_i;

    // a data write while busy is lost, cpu polls busy
    assign xr_start   = wr_stb && (bus_reg_num_i == `XV_REG_XR_DATA) && !busy;
    assign intr_clear = wr_stb && (bus_reg_num_i == `XV_REG_INT_CLEAR) && wr_word[0];

    // even byte waits for its odd partner
    always_ff @(posedge clk) begin
        if (even_wr) begin
            even_byte <= bus_data_i;
        end
    end

    // read mux, value held until next read
    always_ff @(posedge clk) begin
        if (rd_stb) begin
            bus_data_o <= 8'h00;                // other regs and even byte read 0
            if ((bus_reg_num_i == `XV_REG_SYS_CTRL) && bus_bytesel_i) begin
                bus_data_o <= {busy, 5'b00000, intr_mask, intr_status};
            end
        end
    end

    // requesting side of the handshake plus xr address
    always_ff @(posedge clk) begin
        if (reset_i) begin
            xr_req_o  <= 1'b0;
            xr_addr_o <= '0;
        end else begin
            if (xr_start) begin
                xr_req_o <= 1'b1;
            end
            // ack seen: let go of req, step to next word
            if (xr_req_o && xr_ack_i) begin
                xr_req_o  <= 1'b0;
                xr_addr_o <= xr_addr_o + 16'd1;
            end
            if (wr_stb && (bus_reg_num_i == `XV_REG_XR_ADDR)) begin
                xr_addr_o <= wr_word;           // cpu load wins over increment
            end
        end
    end

    // data word captured with the request
    always_ff @(posedge clk) begin
        if (xr_start) begin
            xr_data_o <= wr_word;
        end
    end

    // vblank interrupt, mask and status
    always_ff @(posedge clk) begin
        if (reset_i) begin
            intr_mask   <= 1'b0;
            intr_status <= 1'b0;
            bus_intr_o  <= 1'b0;
        end else begin
            // only signal when nothing is pending yet
            bus_intr_o  <= vblank_start_i && intr_mask && !intr_status;
            intr_status <= (intr_status || vblank_start_i) && !intr_clear;  // clear wins
            if (wr_stb && (bus_reg_num_i == `XV_REG_SYS_CTRL)) begin
                intr_mask <= wr_word[0];
            end
        end
    end

    // req may only drop once ack is up, and ack must still be up then
    a_req_fall_acked: assert property (@(posedge clk) disable iff (reset_i)
        $fell(xr_req_o) |-> xr_ack_i);

endmodule

`default_nettype wire

// ==== logic/xv_xr_palette.sv ====
// xv xr palette with blank-gated xr write port, palette ram and video register strobe
`default_nettype none
`timescale 1ns/1ps

`include "xv_defs.svh"

module xv_xr_palette (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   xr_req_i,       // four-phase request
    input  wire xv_pkg::xr_addr_t       xr_addr_i,
    input  wire logic [15:0]            xr_data_i,
    output logic                        xr_ack_o,       // four-phase ack
    input  wire logic                   blank_i,        // writes only land here
    input  wire xv_pkg::color_index_t   rd_index_i,     // video lookup index
    output xv_pkg::pal_entry_t          rd_color_o,     // one cycle after index
    output logic                        vreg_wr_o,      // color base strobe
    output logic      [15:0]            vreg_data_o
);

    import xv_pkg::*;

    pal_entry_t pal_mem [`XV_PAL_DEPTH];   // 256 x 16 palette
    logic       xr_wr;                      // edge that accepts the request
    logic       pal_wr;

    // new request, not yet acked, screen dark
    assign xr_wr = xr_req_i && !xr_ack_o && blank_i;

    // memory view writes go to the color region at the offset low byte
    assign pal_wr = xr_wr && xr_addr_i.mem.is_mem &&
                    (xr_addr_i.mem.region == `XV_XR_REGION_COLOR);

    // color base is the only video register
    assign vreg_wr_o = xr_wr && !xr_addr_i.regs.is_mem &&
                       (xr_addr_i.regs.reg_num == `XV_VREG_COLOR_BASE);
    assign vreg_data_o = xr_data_i;

    // ack rises with the write, falls once req is gone
    // other addresses still get acked without effect
    always_ff @(posedge clk) begin
        if (reset_i) begin
            xr_ack_o <= 1'b0;
        end else if (xr_wr) begin
            xr_ack_o <= 1'b1;
        end else if (xr_ack_o && !xr_req_i) begin
            xr_ack_o <= 1'b0;
        end
    end

    // write port
    always_ff @(posedge clk) begin
        if (pal_wr) begin
            pal_mem[xr_addr_i.mem.offset[7:0]] <= xr_data_i;
        end
    end

    // registered read port, video side
    always_ff @(posedge clk) begin
        rd_color_o <= pal_mem[rd_index_i];
    end

    // ack only comes up while the producer still holds its request
    a_ack_needs_req: assert property (@(posedge clk) disable iff (reset_i)
        $rose(xr_ack_o) |-> xr_req_i);

endmodule

`default_nettype wire

// ==== logic/xv_video_out.sv ====
// xv video out: frame counters, color ramp index and 2-cycle aligned rgb/sync output
`default_nettype none
`timescale 1ns/1ps

`include "xv_defs.svh"

module xv_video_out (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   vreg_wr_i,      // color base write strobe
    input  wire logic [15:0]            vreg_data_i,
    input  wire xv_pkg::pal_entry_t     rd_color_i,     // palette word, 1 cycle late
    output xv_pkg::color_index_t        rd_index_o,     // palette lookup index
    output logic                        blank_o,        // outside visible area
    output logic                        vblank_start_o, // first clock of line V_VISIBLE
    output logic      [3:0]             red_o,
    output logic      [3:0]             green_o,
    output logic      [3:0]             blue_o,
    output logic                        hsync_o,        // active high
    output logic                        vsync_o,        // active high
    output logic                        dv_de_o         // display enable
);

    import xv_pkg::*;

    localparam int H_BITS = $clog2(`XV_H_TOTAL);
    localparam int V_BITS = $clog2(`XV_V_TOTAL);

    logic [H_BITS-1:0] h_count;     // pixel in line
    logic [V_BITS-1:0] v_count;     // line in frame
    color_index_t      color_base;  // ramp offset
    logic              h_last;
    logic              v_last;
    logic              de_0;        // counter-time enable
    logic              hs_0;
    logic              vs_0;
    logic              de_1;        // palette-read stage
    logic              hs_1;
    logic              vs_1;

    assign h_last = (h_count == H_BITS'(`XV_H_TOTAL - 1));
    assign v_last = (v_count == V_BITS'(`XV_V_TOTAL - 1));

    assign de_0 = (h_count < `XV_H_VISIBLE) && (v_count < `XV_V_VISIBLE);
    assign hs_0 = (h_count >= `XV_H_SYNC_START) && (h_count < `XV_H_SYNC_END);
    assign vs_0 = (v_count >= `XV_V_SYNC_START) && (v_count < `XV_V_SYNC_END);

    assign blank_o        = !de_0;
    assign vblank_start_o = (v_count == V_BITS'(`XV_V_VISIBLE)) && (h_count == '0);
    assign rd_index_o     = color_base + color_index_t'(h_count);  // wraps mod 256

    // pixel and line counters
    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_count <= '0;
            v_count <= '0;
        end else if (h_last) begin
            h_count <= '0;
            v_count <= v_last ? '0 : v_count + 1'b1;
        end else begin
            h_count <= h_count + 1'b1;
        end
    end

    // color base video register
    always_ff @(posedge clk) begin
        if (reset_i) begin
            color_base <= '0;
        end else if (vreg_wr_i) begin
            color_base <= vreg_data_i[7:0];
        end
    end

    // sync and enable follow the two-stage color path
    always_ff @(posedge clk) begin
        if (reset_i) begin
            de_1    <= 1'b0;
            hs_1    <= 1'b0;
            vs_1    <= 1'b0;
            dv_de_o <= 1'b0;
            hsync_o <= 1'b0;
            vsync_o <= 1'b0;
        end else begin
            de_1    <= de_0;
            hs_1    <= hs_0;
            vs_1    <= vs_0;
            dv_de_o <= de_1;
            hsync_o <= hs_1;
            vsync_o <= vs_1;
        end
    end

    // output register, black outside the visible area
    always_ff @(posedge clk) begin
        red_o   <= de_1 ? rd_color_i[11:8] : 4'h0;
        green_o <= de_1 ? rd_color_i[7:4]  : 4'h0;
        blue_o  <= de_1 ? rd_color_i[3:0]  : 4'h0;
    end

endmodule

`default_nettype wire

// ==== logic/xv_top.sv ====
// xv top: bus registers, xr palette and video output tied together
`default_nettype none
`timescale 1ns/1ps

module xv_top (
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire logic           bus_cs_n_i,
    input  wire logic           bus_rd_nwr_i,
    input  wire logic [3:0]     bus_reg_num_i,
    input  wire logic           bus_bytesel_i,
    input  wire logic [7:0]     bus_data_i,
    output logic      [7:0]     bus_data_o,
    output logic                bus_intr_o,
    output logic      [3:0]     red_o,
    output logic      [3:0]     green_o,
    output logic      [3:0]     blue_o,
    output logic                hsync_o,
    output logic                vsync_o,
    output logic                dv_de_o
);

    import xv_pkg::*;

    logic         xr_req;        // bus regs -> palette
    logic         xr_ack;        // palette -> bus regs
    xr_addr_t     xr_addr;
    logic [15:0]  xr_data;
    logic         blank;
    logic         vblank_start;  // interrupt source
    color_index_t rd_index;
    pal_entry_t   rd_color;
    logic         vreg_wr;
    logic [15:0]  vreg_data;

    // producer
    xv_bus_regs i_bus_regs (
        .clk            (clk),
        .reset_i        (reset_i),
        .bus_cs_n_i     (bus_cs_n_i),
        .bus_rd_nwr_i   (bus_rd_nwr_i),
        .bus_reg_num_i  (bus_reg_num_i),
        .bus_bytesel_i  (bus_bytesel_i),
        .bus_data_i     (bus_data_i),
        .bus_data_o     (bus_data_o),
        .bus_intr_o     (bus_intr_o),
        .xr_req_o       (xr_req),
        .xr_ack_i       (xr_ack),
        .xr_addr_o      (xr_addr),
        .xr_data_o      (xr_data),
        .vblank_start_i (vblank_start)
    );

    // buffer, writes held until blank
    xv_xr_palette i_xr_palette (
        .clk            (clk),
        .reset_i        (reset_i),
        .xr_req_i       (xr_req),
        .xr_addr_i      (xr_addr),
        .xr_data_i      (xr_data),
        .xr_ack_o       (xr_ack),
        .blank_i        (blank),
        .rd_index_i     (rd_index),
        .rd_color_o     (rd_color),
        .vreg_wr_o      (vreg_wr),
        .vreg_data_o    (vreg_data)
    );

    // consumer
    xv_video_out i_video_out (
        .clk            (clk),
        .reset_i        (reset_i),
        .vreg_wr_i      (vreg_wr),
        .vreg_data_i    (vreg_data),
        .rd_color_i     (rd_color),
        .rd_index_o     (rd_index),
        .blank_o        (blank),
        .vblank_start_o (vblank_start),
        .red_o          (red_o),
        .green_o        (green_o),
        .blue_o         (blue_o),
        .hsync_o        (hsync_o),
        .vsync_o        (vsync_o),
        .dv_de_o        (dv_de_o)
    );

endmodule

`default_nettype wire

// ==== dv/xv_tb.sv ====
// xv testbench checking golden-file bus commands against palette, pixel and interrupt models
`default_nettype none
`timescale 1ns/1ps

`include "xv_defs.svh"

module xv_tb;

    localparam int FRAME = `XV_H_TOTAL * `XV_V_TOTAL;   // clocks per frame

    logic        clk = 1'b0;
    logic        reset_i;
    logic        cs_n;
    logic        rd_nwr;
    logic [3:0]  reg_num;
    logic        bytesel;
    logic [7:0]  data_in;
    logic [7:0]  data_out;
    logic        bus_intr;
    logic [3:0]  red;
    logic [3:0]  green;
    logic [3:0]  blue;
    logic        hsync;
    logic        vsync;
    logic        dv_de;
    logic [39:0] golden [64];       // op, reg, arg, expected, mask
    logic [11:0] pal_model [256];   // rgb part of each palette word
    logic [7:0]  base_model;
    logic [15:0] addr_model;        // xr address incl. auto-increment
    logic [3:0]  op;
    logic [3:0]  num;
    logic [15:0] arg;
    logic [7:0]  ref_byte;
    logic [7:0]  mask_byte;
    logic [7:0]  rd_byte;
    logic [31:0] rnd;
    int          cycles = 0;
    int          limit = 64;        // reset plus margin
    int          errors = 0;
    int          checks = 0;
    int          step;
    int          err_before;
    int          pulses;

    xv_top i_xv_top (
        .clk(clk), .reset_i(reset_i), .bus_cs_n_i(cs_n), .bus_rd_nwr_i(rd_nwr),
        .bus_reg_num_i(reg_num), .bus_bytesel_i(bytesel), .bus_data_i(data_in),
        .bus_data_o(data_out), .bus_intr_o(bus_intr), .red_o(red), .green_o(green),
        .blue_o(blue), .hsync_o(hsync), .vsync_o(vsync), .dv_de_o(dv_de)
    );

    always #5 clk = ~clk;

    // watchdog
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("timeout after %0d cycles, step %0d never finished", cycles, step);
            $display("test failed");
            $finish;
        end
    end

    task automatic value_error(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        errors++;
        $display("MISMATCH at %0t: step %0d %s, got %h expected %h",
                 $time, step, what, got, want);
    endtask

    // writes the even byte then the odd byte and updates the model
    task automatic write_word(input logic [3:0] num_w, input logic [15:0] word);
        @(posedge clk);
        cs_n    <= 1'b0;
        rd_nwr  <= 1'b0;
        reg_num <= num_w;
        bytesel <= 1'b0;
        data_in <= word[15:8];
        @(posedge clk);
        bytesel <= 1'b1;
        data_in <= word[7:0];
        @(posedge clk);
        cs_n    <= 1'b1;
        if (num_w == `XV_REG_XR_ADDR) begin
            addr_model = word;
        end else if (num_w == `XV_REG_XR_DATA) begin
            if (addr_model[15] && addr_model[13:12] == `XV_XR_REGION_COLOR) begin
                pal_model[addr_model[7:0]] = word[11:0];
            end else if (!addr_model[15] && addr_model[4:0] == `XV_VREG_COLOR_BASE) begin
                base_model = word[7:0];
            end
            addr_model = addr_model + 16'd1;    // any target steps the address
        end
    endtask

    task automatic read_reg(input logic [3:0] num_r, input logic sel);
        @(posedge clk);
        cs_n    <= 1'b0;
        rd_nwr  <= 1'b1;
        reg_num <= num_r;
        bytesel <= sel;
        @(posedge clk);
        cs_n    <= 1'b1;
        @(negedge clk);
        rd_byte = data_out;     // valid the cycle after the access
    endtask

    task automatic poll_busy();
        int polls;
        polls = 0;
        rd_byte = 8'h80;
        while (rd_byte[7] && polls < FRAME) begin
            read_reg(`XV_REG_SYS_CTRL, 1'b1);
            polls++;
        end
        checks++;
        if (rd_byte[7]) begin
            errors++;
            $display("busy bit never cleared, step %0d at %0t", step, $time);
        end
    endtask

    task automatic check_frame();
        logic [14:0] want;
        logic [7:0]  idx;
        logic        de;
        // lock onto pixel 0,0 after vsync
        @(negedge clk);
        while (!vsync) @(negedge clk);
        while (vsync) @(negedge clk);
        while (!dv_de) @(negedge clk);
        for (int y = 0; y < `XV_V_TOTAL; y++) begin
            for (int x = 0; x < `XV_H_TOTAL; x++) begin
                idx  = base_model + 8'(x);      // ramp wraps mod 256
                de   = (x < `XV_H_VISIBLE) && (y < `XV_V_VISIBLE);
                want = {de, (x >= `XV_H_SYNC_START) && (x < `XV_H_SYNC_END),
                        (y >= `XV_V_SYNC_START) && (y < `XV_V_SYNC_END),
                        de ? pal_model[idx] : 12'h000};  // black outside de
                checks++;
                if ({dv_de, hsync, vsync, red, green, blue} !== want) begin
                    value_error($sformatf("pixel %0d,%0d de/hs/vs/rgb", x, y),
                                {dv_de, hsync, vsync, red, green, blue}, want);
                end
                @(negedge clk);
            end
        end
    endtask

    task automatic watch_intr(input int span, input logic stop_at_first);
        pulses = 0;
        for (int n = 0; n < span && !(stop_at_first && pulses > 0); n++) begin
            @(negedge clk);
            pulses += int'(bus_intr);
        end
    endtask

    initial begin
        rnd      = $urandom(11778);
        reset_i  <= 1'b1;
        cs_n     <= 1'b1;
        rd_nwr   <= 1'b1;
        reg_num  <= 4'd0;
        bytesel  <= 1'b0;
        data_in  <= 8'h00;
        base_model = 8'h00;     // reset value of color base
        addr_model = 16'h0000;
        for (int i = 0; i < 64; i++) golden[i] = '0;
        $readmemh("dv/xv_golden.txt", golden);
        // cycle budget per command from its length
        for (int i = 0; i < 64 && golden[i][39:36] != 4'd0; i++) begin
            case (golden[i][39:36])
                4'd2: limit += int'(golden[i][31:16]) * 40;
                4'd5, 4'd6: limit += 3 * FRAME;
                4'd4, 4'd7: limit += 2 * FRAME;
                default: limit += 16;
            endcase
        end
        repeat (3) @(posedge clk);
        reset_i <= 1'b0;
        for (step = 0; step < 64 && golden[step][39:36] != 4'd0; step++) begin
            {op, num, arg, ref_byte, mask_byte} = golden[step];
            err_before = errors;
            case (op)
                4'd1: write_word(num, arg);
                4'd2: begin
                    repeat (arg) begin
                        rnd = $urandom();
                        write_word(`XV_REG_XR_DATA, rnd[15:0]);
                        poll_busy();
                    end
                end
                4'd3: begin
                    read_reg(num, arg[0]);
                    checks++;
                    if ((rd_byte & mask_byte) !== (ref_byte & mask_byte)) begin
                        value_error("bus read", rd_byte, ref_byte);
                    end
                    // high half of the status word stays zero, also with bits set
                    if ((num == `XV_REG_SYS_CTRL) && arg[0]) begin
                        read_reg(num, 1'b0);
                        checks++;
                        if (rd_byte !== 8'h00) begin
                            value_error("sys_ctrl even byte", rd_byte, 8'h00);
                        end
                    end
                end
                4'd4: poll_busy();
                4'd5: check_frame();
                4'd6: begin
                    watch_intr(3 * FRAME, 1'b1);
                    checks++;
                    if (pulses == 0) begin
                        errors++;
                        $display("no interrupt pulse within 3 frames, at %0t", $time);
                    end
                end
                4'd7: begin
                    watch_intr(FRAME, 1'b0);
                    checks++;
                    if (pulses != int'(ref_byte)) begin
                        value_error("interrupt pulses in one frame", pulses, ref_byte);
                    end
                end
                default: begin
                    errors++;
                    $display("unknown command %h in golden step %0d", op, step);
                end
            endcase
            $display("step %0d op %0d: %s", step, op, (errors == err_before) ? "ok" : "FAILED");
        end
        if (step == 0) begin
            errors++;
            $display("golden file held no commands");
        end
        $display("%0d steps, %0d checks, %0d errors", step, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+logic
logic/xv_pkg.sv
logic/xv_bus_regs.sv
logic/xv_xr_palette.sv
logic/xv_video_out.sv
logic/xv_top.sv
dv/xv_tb.sv

// ==== Makefile ====
SIM      := verilator
SIMFLAGS := --binary --timing --assert -Wno-fatal
TOP      := xv_tb
FILELIST := sim.f
OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
LOG      := sim.log
SRCS     := $(shell grep -v '^+' $(FILELIST)) $(wildcard logic/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@! grep -q "test failed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== dv/xv_golden.txt ====
// xv commands, one 40-bit hex word per line: op(1) reg(1) arg(4) expected(2) mask(2)
// op 1 write word, 2 fill palette with arg random words, 3 read (arg bit 0 = byte select)
// op 4 poll busy, 5 check frame, 6 wait for intr, 7 count intr pulses in a frame, 0 end
32000100ff  // sys_ctrl reads zero after reset
32000000ff  // even byte reads zero
7000000000  // masked, no pulse
1080000000  // xr addr = color region, entry 0
2001000000  // 256 palette words
5000000000  // ramp with base 0
1000000000  // xr addr = register view, color base
1100c30000  // base 0xc3
4000000000
5000000000
1090050000  // region 1, no pixel effect
110fff0000
3200018080  // busy right after the data write
4000000000
3200010080  // busy gone
5000000000
1200010000  // mask on
1300010000  // clear old status
6000000000
3200010303  // mask and status set
7000000000  // no second pulse while pending
3200010303
1300010000
6000000000  // pulse again after clear
3200010303
0000000000
